// ==== src/cacheSys_params.svh ====
`ifndef CACHESYS_PARAMS_SVH
`define CACHESYS_PARAMS_SVH

// Bus and word widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// Cache geometry
// Words per line, also the refill burst length
`define LINE_WORDS 4
// Lines per cache
`define NUM_LINES 16

// Backing memory depth in words, addresses wrap
`define MEM_WORDS 1024

// Derived address fields
`define SEL_WIDTH (`DATA_WIDTH / 8)
`define BYTE_OFF_BITS $clog2(`SEL_WIDTH)
`define OFFSET_BITS $clog2(`LINE_WORDS)
`define INDEX_BITS $clog2(`NUM_LINES)
// Tag takes whatever is left above index and offset
`define TAG_BITS (`ADDR_WIDTH - `INDEX_BITS - `OFFSET_BITS - `BYTE_OFF_BITS)
`define MEM_ADDR_BITS $clog2(`MEM_WORDS)

`endif

// ==== src/cacheSysPkg.sv ====
package cacheSysPkg;

  // Cache controller states
  // Instruction side never enters StWrite
  typedef enum logic [1:0] {
    StIdle,
    // Line fetch, one word per bus beat
    StRefill,
    // Single write-through cycle
    StWrite
  } cacheStateT;

  // Who holds the shared bus
  typedef enum logic [1:0] {
    OwnerNone,
    OwnerInstr,
    OwnerData
  } busOwnerT;

endpackage

// ==== src/instrCache.sv ====
`timescale 1ns/1ps
`include "cacheSys_params.svh"

module instrCache
  import cacheSysPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   invalidate,
  input  logic [`ADDR_WIDTH-1:0] pc,
  output logic [`DATA_WIDTH-1:0] instr,
  output logic                   stall,
  output logic                   cyc,
  output logic                   stb,
  output logic [`ADDR_WIDTH-1:0] adr,
  input  logic [`DATA_WIDTH-1:0] datR,
  input  logic                   ack
);

  cacheStateT state;

  // Tag, valid and data storage
  logic [`NUM_LINES-1:0]  validBits;
  logic [`TAG_BITS-1:0]   tagArray  [`NUM_LINES];
  logic [`DATA_WIDTH-1:0] dataArray [`NUM_LINES*`LINE_WORDS];

  // Fields of the fetch address
  logic [`TAG_BITS-1:0]    pcTag;
  logic [`INDEX_BITS-1:0]  pcIndex;
  logic [`OFFSET_BITS-1:0] pcOffset;
  logic                    hit;

  // Line under refill, captured when the miss is seen
  logic [`TAG_BITS-1:0]    fillTag;
  logic [`INDEX_BITS-1:0]  fillIndex;
  logic [`OFFSET_BITS-1:0] wordCnt;

  assign pcTag    = pc[`ADDR_WIDTH-1 -: `TAG_BITS];
  assign pcIndex  = pc[`BYTE_OFF_BITS + `OFFSET_BITS +: `INDEX_BITS];
  assign pcOffset = pc[`BYTE_OFF_BITS +: `OFFSET_BITS];

  // Hit path answers in the same cycle
  assign hit   = validBits[pcIndex] && (tagArray[pcIndex] == pcTag);
  assign instr = dataArray[{pcIndex, pcOffset}];
  assign stall = !hit;

  // Burst reads, stb held high across the whole line
  assign cyc = (state == StRefill);
  assign stb = cyc;
  assign adr = {fillTag, fillIndex, wordCnt, {`BYTE_OFF_BITS{1'b0}}};

  // Controller and valid bits
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= StIdle;
      validBits <= '0;
      wordCnt   <= '0;
    end else begin
      // Flush request, dropped during a refill
      if (invalidate && state != StRefill)
        validBits <= '0;
      case (state)
        StIdle: begin
          if (!hit) begin
            validBits[pcIndex] <= 1'b0;
            state              <= StRefill;
          end
        end
        StRefill: begin
          if (ack) begin
            wordCnt <= wordCnt + 1'b1;
            // Last word of the line
            if (&wordCnt) begin
              validBits[fillIndex] <= 1'b1;
              state                <= StIdle;
            end
          end
        end
        default: state <= StIdle;
      endcase
    end
  end

  // Line storage and refill address capture
  always_ff @(posedge clk) begin
    if (state == StIdle && !hit) begin
      fillTag   <= pcTag;
      fillIndex <= pcIndex;
    end
    if (state == StRefill && ack) begin
      dataArray[{fillIndex, wordCnt}] <= datR;
      if (&wordCnt)
        tagArray[fillIndex] <= fillTag;
    end
  end

  // Address must hold until memory has taken the beat
  adrStableA: assert property (@(posedge clk) disable iff (reset)
    (stb && !ack) |=> $stable(adr))
    else $error("instrCache: adr changed before ack");

endmodule

// ==== src/dataCache.sv ====
`timescale 1ns/1ps
`include "cacheSys_params.svh"

module dataCache
  import cacheSysPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   invalidate,
  input  logic [`ADDR_WIDTH-1:0] adr,
  input  logic [`DATA_WIDTH-1:0] writeData,
  input  logic [`SEL_WIDTH-1:0]  byteMask,
  input  logic                   memWrite,
  input  logic                   memToReg,
  output logic [`DATA_WIDTH-1:0] readData,
  output logic                   stall,
  output logic                   cyc,
  output logic                   stb,
  output logic                   we,
  output logic [`SEL_WIDTH-1:0]  sel,
  output logic [`ADDR_WIDTH-1:0] wbAdr,
  output logic [`DATA_WIDTH-1:0] datW,
  input  logic [`DATA_WIDTH-1:0] datR,
  input  logic                   ack
);

  cacheStateT state;
  // Store just finished, lets the held request retire
  logic writeDone;

  logic [`NUM_LINES-1:0]  validBits;
  logic [`TAG_BITS-1:0]   tagArray  [`NUM_LINES];
  logic [`DATA_WIDTH-1:0] dataArray [`NUM_LINES*`LINE_WORDS];

  logic [`TAG_BITS-1:0]    adrTag;
  logic [`INDEX_BITS-1:0]  adrIndex;
  logic [`OFFSET_BITS-1:0] adrOffset;
  logic                    hit;

  logic [`TAG_BITS-1:0]    fillTag;
  logic [`INDEX_BITS-1:0]  fillIndex;
  logic [`OFFSET_BITS-1:0] wordCnt;

  assign adrTag    = adr[`ADDR_WIDTH-1 -: `TAG_BITS];
  assign adrIndex  = adr[`BYTE_OFF_BITS + `OFFSET_BITS +: `INDEX_BITS];
  assign adrOffset = adr[`BYTE_OFF_BITS +: `OFFSET_BITS];

  assign hit      = validBits[adrIndex] && (tagArray[adrIndex] == adrTag);
  assign readData = dataArray[{adrIndex, adrOffset}];

  // Stores always stall until the write is acked, loads only on a miss
  always_comb begin
    case (state)
      StIdle:  stall = (memWrite && !writeDone) || (memToReg && !hit);
      default: stall = 1'b1;
    endcase
  end

  // Wishbone master side
  assign cyc   = (state != StIdle);
  assign stb   = cyc;
  assign we    = (state == StWrite);
  assign sel   = we ? byteMask : '1;
  assign datW  = writeData;
  assign wbAdr = (state == StRefill) ?
                 {fillTag, fillIndex, wordCnt, {`BYTE_OFF_BITS{1'b0}}} :
                 {adr[`ADDR_WIDTH-1:`BYTE_OFF_BITS], {`BYTE_OFF_BITS{1'b0}}};

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= StIdle;
      writeDone <= 1'b0;
      validBits <= '0;
      wordCnt   <= '0;
    end else begin
      writeDone <= 1'b0;
      if (invalidate && state != StRefill)
        validBits <= '0;
      case (state)
        StIdle: begin
          // Store wins, a load miss starts a line fetch
          if (memWrite && !writeDone) begin
            state <= StWrite;
          end else if (memToReg && !hit) begin
            validBits[adrIndex] <= 1'b0;
            state               <= StRefill;
          end
        end
        StRefill: begin
          if (ack) begin
            wordCnt <= wordCnt + 1'b1;
            if (&wordCnt) begin
              validBits[fillIndex] <= 1'b1;
              state                <= StIdle;
            end
          end
        end
        StWrite: begin
          if (ack) begin
            writeDone <= 1'b1;
            state     <= StIdle;
          end
        end
        default: state <= StIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == StIdle && !(memWrite && !writeDone) && memToReg && !hit) begin
      fillTag   <= adrTag;
      fillIndex <= adrIndex;
    end
    if (state == StRefill && ack) begin
      dataArray[{fillIndex, wordCnt}] <= datR;
      if (&wordCnt)
        tagArray[fillIndex] <= fillTag;
    end
    // No allocate on a store miss, patch the cached copy on a hit
    if (state == StWrite && ack && hit) begin
      for (int b = 0; b < `SEL_WIDTH; b++) begin
        if (byteMask[b])
          dataArray[{adrIndex, adrOffset}][8*b +: 8] <= writeData[8*b +: 8];
      end
    end
  end

  // Core issues one kind of access at a time
  oneOpA: assert property (@(posedge clk) disable iff (reset)
    !(memWrite && memToReg))
    else $error("dataCache: load and store requested together");

  // Refill beats are reads
  refillReadA: assert property (@(posedge clk) disable iff (reset)
    (state == StRefill) |-> !we)
    else $error("dataCache: write enable during refill");

endmodule

// ==== src/busArbiter.sv ====
`timescale 1ns/1ps
`include "cacheSys_params.svh"

module busArbiter
  import cacheSysPkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  // Instruction cache master
  input  logic                   iCyc,
  input  logic                   iStb,
  input  logic [`ADDR_WIDTH-1:0] iAdr,
  // Data cache master
  input  logic                   dCyc,
  input  logic                   dStb,
  input  logic                   dWe,
  input  logic [`SEL_WIDTH-1:0]  dSel,
  input  logic [`ADDR_WIDTH-1:0] dAdr,
  input  logic [`DATA_WIDTH-1:0] dDatW,
  output logic                   iAck,
  output logic                   dAck,
  // Memory slave side
  output logic                   memCyc,
  output logic                   memStb,
  output logic                   memWe,
  output logic [`SEL_WIDTH-1:0]  memSel,
  output logic [`ADDR_WIDTH-1:0] memAdr,
  output logic [`DATA_WIDTH-1:0] memDatW,
  input  logic                   memAck
);

  busOwnerT ownerQ;
  busOwnerT grant;

  // Free bus picks a new owner this cycle, data side first
  always_comb begin
    if (ownerQ != OwnerNone)
      grant = ownerQ;
    else if (dCyc)
      grant = OwnerData;
    else if (iCyc)
      grant = OwnerInstr;
    else
      grant = OwnerNone;
  end

  // Grant held for the owner's whole bus cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      ownerQ <= OwnerNone;
    end else begin
      case (ownerQ)
        OwnerNone:  ownerQ <= grant;
        OwnerInstr: if (!iCyc) ownerQ <= OwnerNone;
        OwnerData:  if (!dCyc) ownerQ <= OwnerNone;
        default:    ownerQ <= OwnerNone;
      endcase
    end
  end

  // Owner's signals onto the slave
  always_comb begin
    memCyc = 1'b0;
    memStb = 1'b0;
    memWe  = 1'b0;
    memSel = '0;
    memAdr = '0;
    case (grant)
      OwnerData: begin
        memCyc = dCyc;
        memStb = dStb;
        memWe  = dWe;
        memSel = dSel;
        memAdr = dAdr;
      end
      OwnerInstr: begin
        memCyc = iCyc;
        memStb = iStb;
        memSel = '1;
        memAdr = iAdr;
      end
      default: ;
    endcase
  end

  // Only the data side ever writes
  assign memDatW = dDatW;

  // Waiting master sees no ack
  assign iAck = memAck && (grant == OwnerInstr);
  assign dAck = memAck && (grant == OwnerData);

  oneAckA: assert property (@(posedge clk) disable iff (reset)
    !(iAck && dAck))
    else $error("busArbiter: ack routed to both masters");

  ackToOwnerA: assert property (@(posedge clk) disable iff (reset)
    (iAck || dAck) |-> (ownerQ != OwnerNone))
    else $error("busArbiter: ack with no registered owner");

endmodule

// ==== src/wbMemory.sv ====
`timescale 1ns/1ps
`include "cacheSys_params.svh"

module wbMemory (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cyc,
  input  logic                   stb,
  input  logic                   we,
  input  logic [`SEL_WIDTH-1:0]  sel,
  input  logic [`ADDR_WIDTH-1:0] adr,
  input  logic [`DATA_WIDTH-1:0] datW,
  output logic [`DATA_WIDTH-1:0] datR,
  output logic                   ack
);

  logic [`DATA_WIDTH-1:0]   mem [`MEM_WORDS];
  logic [`MEM_ADDR_BITS-1:0] wordIdx;
  // New beat, not the one being acked now
  logic                     access;

  // Upper address bits ignored, so the space wraps
  assign wordIdx = adr[`BYTE_OFF_BITS +: `MEM_ADDR_BITS];
  assign access  = cyc && stb && !ack;

  // Powers up as zeros
  initial begin
    for (int i = 0; i < `MEM_WORDS; i++)
      mem[i] = '0;
  end

  // One-cycle ack, one clock after the request
  always_ff @(posedge clk) begin
    if (reset)
      ack <= 1'b0;
    else
      ack <= access;
  end

  // Byte lane writes, read data lands with ack
  always_ff @(posedge clk) begin
    if (access) begin
      if (we) begin
        for (int b = 0; b < `SEL_WIDTH; b++) begin
          if (sel[b])
            mem[wordIdx][8*b +: 8] <= datW[8*b +: 8];
        end
      end
      datR <= mem[wordIdx];
    end
  end

  ackCycA: assert property (@(posedge clk) disable iff (reset)
    ack |-> $past(cyc))
    else $error("wbMemory: ack without a bus cycle");

endmodule

// ==== src/memSystem.sv ====
`timescale 1ns/1ps
`include "cacheSys_params.svh"

module memSystem (
  input  logic                   clk,
  input  logic                   reset,
  // Fetch port
  input  logic [`ADDR_WIDTH-1:0] pcF,
  output logic [`DATA_WIDTH-1:0] instrF,
  output logic                   iStall,
  input  logic                   invalidateI,
  // Load/store port
  input  logic [`ADDR_WIDTH-1:0] dataAdrM,
  input  logic [`DATA_WIDTH-1:0] writeDataM,
  input  logic [`SEL_WIDTH-1:0]  byteMaskM,
  input  logic                   memWriteM,
  input  logic                   memToRegM,
  output logic [`DATA_WIDTH-1:0] readDataM,
  output logic                   dStall,
  input  logic                   invalidateD
);

  // Instruction cache master
  logic                   iCyc, iStb, iAck;
  logic [`ADDR_WIDTH-1:0] iAdr;
  // Data cache master
  logic                   dCyc, dStb, dWe, dAck;
  logic [`SEL_WIDTH-1:0]  dSel;
  logic [`ADDR_WIDTH-1:0] dAdr;
  logic [`DATA_WIDTH-1:0] dDatW;
  // Shared slave bus, read data fans out to both caches
  logic                   memCyc, memStb, memWe, memAck;
  logic [`SEL_WIDTH-1:0]  memSel;
  logic [`ADDR_WIDTH-1:0] memAdr;
  logic [`DATA_WIDTH-1:0] memDatW, memDatR;

  instrCache iCache (
    .clk(clk), .reset(reset), .invalidate(invalidateI),
    .pc(pcF), .instr(instrF), .stall(iStall),
    .cyc(iCyc), .stb(iStb), .adr(iAdr), .datR(memDatR), .ack(iAck)
  );

  dataCache dCache (
    .clk(clk), .reset(reset), .invalidate(invalidateD),
    .adr(dataAdrM), .writeData(writeDataM), .byteMask(byteMaskM),
    .memWrite(memWriteM), .memToReg(memToRegM),
    .readData(readDataM), .stall(dStall),
    .cyc(dCyc), .stb(dStb), .we(dWe), .sel(dSel), .wbAdr(dAdr),
    .datW(dDatW), .datR(memDatR), .ack(dAck)
  );

  busArbiter arbiter (
    .clk(clk), .reset(reset),
    .iCyc(iCyc), .iStb(iStb), .iAdr(iAdr),
    .dCyc(dCyc), .dStb(dStb), .dWe(dWe), .dSel(dSel), .dAdr(dAdr), .dDatW(dDatW),
    .iAck(iAck), .dAck(dAck),
    .memCyc(memCyc), .memStb(memStb), .memWe(memWe), .memSel(memSel),
    .memAdr(memAdr), .memDatW(memDatW), .memAck(memAck)
  );

  wbMemory memory (
    .clk(clk), .reset(reset),
    .cyc(memCyc), .stb(memStb), .we(memWe), .sel(memSel),
    .adr(memAdr), .datW(memDatW), .datR(memDatR), .ack(memAck)
  );

endmodule

// ==== testbench/memSystemTb.sv ====
`timescale 1ns/1ps
`include "cacheSys_params.svh"

module memSystemTb;

  typedef enum logic [2:0] {
    OpStore,
    OpLoad,
    OpFetch,
    OpInvI,
    OpInvD,
    // Fetch and load of one address in the same cycle
    OpFetchLoad
  } opT;

  typedef struct packed {
    opT                     op;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] data;
    logic [`SEL_WIDTH-1:0]  mask;
    logic [`DATA_WIDTH-1:0] expVal;
    // Load has to answer in its first cycle
    logic                   mustHit;
  } entryT;

  localparam int TableLen  = 18;
  localparam int RandOps   = 64;
  // Random fetch costs two ops for the flush and the fetch
  localparam int MaxCycles = 40 * (TableLen + 2 * RandOps) + 8;

  logic                   clk;
  logic                   reset;
  logic [`ADDR_WIDTH-1:0] pcF;
  logic [`DATA_WIDTH-1:0] instrF;
  logic                   iStall;
  logic                   invalidateI;
  logic [`ADDR_WIDTH-1:0] dataAdrM;
  logic [`DATA_WIDTH-1:0] writeDataM;
  logic [`SEL_WIDTH-1:0]  byteMaskM;
  logic                   memWriteM;
  logic                   memToRegM;
  logic [`DATA_WIDTH-1:0] readDataM;
  logic                   dStall;
  logic                   invalidateD;

  // Expected memory contents that start as zeros like the DUT
  logic [`DATA_WIDTH-1:0] shadowMem [`MEM_WORDS];
  logic [31:0]            randState = 32'h2f9d;
  int                     cycleCount = 0;

  entryT stimTable [TableLen] = '{
    '{OpStore,     32'h0000_0100, 32'h1122_3344, 4'b1111, 32'h0,         1'b0},
    '{OpStore,     32'h0000_0104, 32'h5566_7788, 4'b1111, 32'h0,         1'b0},
    // Miss brings the whole line in
    '{OpLoad,      32'h0000_0100, 32'h0,         4'b0000, 32'h1122_3344, 1'b0},
    '{OpLoad,      32'h0000_0104, 32'h0,         4'b0000, 32'h5566_7788, 1'b1},
    // Two low bytes only
    '{OpStore,     32'h0000_0104, 32'hAABB_CCDD, 4'b0011, 32'h0,         1'b0},
    '{OpLoad,      32'h0000_0104, 32'h0,         4'b0000, 32'h5566_CCDD, 1'b1},
    '{OpStore,     32'h0000_0108, 32'h0BAD_F00D, 4'b1111, 32'h0,         1'b0},
    '{OpLoad,      32'h0000_0108, 32'h0,         4'b0000, 32'h0BAD_F00D, 1'b1},
    '{OpFetch,     32'h0000_0108, 32'h0,         4'b0000, 32'h0BAD_F00D, 1'b0},
    // Code rewrite then flush and refetch
    '{OpStore,     32'h0000_0108, 32'h1234_5678, 4'b1111, 32'h0,         1'b0},
    '{OpInvI,      32'h0,         32'h0,         4'b0000, 32'h0,         1'b0},
    '{OpFetch,     32'h0000_0108, 32'h0,         4'b0000, 32'h1234_5678, 1'b0},
    // Partial write must have reached memory
    '{OpInvD,      32'h0,         32'h0,         4'b0000, 32'h0,         1'b0},
    '{OpLoad,      32'h0000_0104, 32'h0,         4'b0000, 32'h5566_CCDD, 1'b0},
    // Both caches miss at once on a fresh line
    '{OpStore,     32'h0000_02A0, 32'hDEAD_BEEF, 4'b1111, 32'h0,         1'b0},
    '{OpFetchLoad, 32'h0000_02A0, 32'h0,         4'b0000, 32'hDEAD_BEEF, 1'b0},
    // Wraps onto word 0
    '{OpStore,     32'h0000_1000, 32'h0F0F_0F0F, 4'b1100, 32'h0,         1'b0},
    '{OpLoad,      32'h0000_0000, 32'h0,         4'b0000, 32'h0F0F_0000, 1'b0}
  };

  memSystem DUT (
    .clk(clk), .reset(reset),
    .pcF(pcF), .instrF(instrF), .iStall(iStall), .invalidateI(invalidateI),
    .dataAdrM(dataAdrM), .writeDataM(writeDataM), .byteMaskM(byteMaskM),
    .memWriteM(memWriteM), .memToRegM(memToRegM),
    .readDataM(readDataM), .dStall(dStall), .invalidateD(invalidateD)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Hang guard
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > MaxCycles) begin
      $display("Timeout: no finish within %0d clock cycles", MaxCycles);
      $display("Regression failed");
      $fatal(1, "timeout");
    end
  end

  // LCG with halves swapped since low bits cycle fast
  function automatic logic [31:0] nextRand();
    randState = randState * 32'd1103515245 + 32'd12345;
    return {randState[15:0], randState[31:16]};
  endfunction

  // Memory is word addressed and wraps at its depth
  function automatic int wordIndex(logic [`ADDR_WIDTH-1:0] a);
    return int'(a[`BYTE_OFF_BITS +: `MEM_ADDR_BITS]);
  endfunction

  function automatic logic [`DATA_WIDTH-1:0] mergeBytes(
    logic [`DATA_WIDTH-1:0] oldWord,
    logic [`DATA_WIDTH-1:0] newWord,
    logic [`SEL_WIDTH-1:0]  mask
  );
    logic [`DATA_WIDTH-1:0] merged;
    merged = oldWord;
    for (int b = 0; b < `SEL_WIDTH; b++) begin
      if (mask[b])
        merged[8*b +: 8] = newWord[8*b +: 8];
    end
    return merged;
  endfunction

  // Stall that ends the given op
  function automatic logic stallFor(opT op);
    case (op)
      OpFetch:     return iStall;
      OpFetchLoad: return iStall || dStall;
      default:     return dStall;
    endcase
  endfunction

  task automatic checkValue(string name, logic [`DATA_WIDTH-1:0] expV,
                            logic [`DATA_WIDTH-1:0] actV);
    assert (actV === expV)
    else begin
      $display("ERR %s expected %08h actual %08h", name, expV, actV);
      $display("Regression failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic applyOp(entryT e, string name);
    int idx;
    idx = wordIndex(e.addr);
    @(negedge clk);
    memWriteM   = 1'b0;
    memToRegM   = 1'b0;
    invalidateI = 1'b0;
    invalidateD = 1'b0;
    case (e.op)
      OpStore: begin
        dataAdrM   = e.addr;
        writeDataM = e.data;
        byteMaskM  = e.mask;
        memWriteM  = 1'b1;
        shadowMem[idx] = mergeBytes(shadowMem[idx], e.data, e.mask);
      end
      OpLoad: begin
        dataAdrM  = e.addr;
        memToRegM = 1'b1;
      end
      OpFetch:
        pcF = e.addr;
      OpFetchLoad: begin
        pcF       = e.addr;
        dataAdrM  = e.addr;
        memToRegM = 1'b1;
      end
      default: ;
    endcase
    if (e.op == OpInvI || e.op == OpInvD) begin
      // Clear is dropped mid refill so wait for an idle cache
      while (e.op == OpInvI ? iStall : dStall)
        @(negedge clk);
      if (e.op == OpInvI)
        invalidateI = 1'b1;
      else
        invalidateD = 1'b1;
      @(negedge clk);
      invalidateI = 1'b0;
      invalidateD = 1'b0;
    end else begin
      @(posedge clk);
      if (e.mustHit) begin
        assert (!dStall)
        else begin
          $display("%s: load in a cached line stalled in its first cycle", name);
          $display("Regression failed");
          $fatal(1, "hit stalled");
        end
      end
      while (stallFor(e.op))
        @(posedge clk);
      if (e.op == OpLoad || e.op == OpFetchLoad)
        checkValue(name, e.expVal, readDataM);
      if (e.op == OpFetch || e.op == OpFetchLoad)
        checkValue({name, " instr"}, e.expVal, instrF);
    end
  endtask

  initial begin
    entryT       e;
    logic [31:0] rnd;
    reset       = 1'b1;
    pcF         = '0;
    invalidateI = 1'b0;
    dataAdrM    = '0;
    writeDataM  = '0;
    byteMaskM   = '0;
    memWriteM   = 1'b0;
    memToRegM   = 1'b0;
    invalidateD = 1'b0;
    for (int i = 0; i < `MEM_WORDS; i++)
      shadowMem[i] = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < TableLen; i++) begin
      e = stimTable[i];
      applyOp(e, $sformatf("table %0d %s", i, e.op.name()));
    end

    // Small window below the wrap so hits and conflict misses both happen
    for (int i = 0; i < RandOps; i++) begin
      rnd    = nextRand();
      e      = '0;
      e.addr = nextRand() & 32'h0000_03FC;
      case (rnd % 3)
        0: begin
          e.op   = OpStore;
          e.data = nextRand();
          rnd    = nextRand();
          e.mask = rnd[`SEL_WIDTH-1:0];
        end
        1: begin
          e.op     = OpLoad;
          e.expVal = shadowMem[wordIndex(e.addr)];
        end
        default: begin
          // No coherence so flush the instruction side before fetching
          e.op = OpInvI;
          applyOp(e, $sformatf("random %0d flush", i));
          e.op     = OpFetch;
          e.expVal = shadowMem[wordIndex(e.addr)];
        end
      endcase
      applyOp(e, $sformatf("random %0d %s", i, e.op.name()));
    end

    $display("Regression passed");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+src
src/cacheSysPkg.sv
src/instrCache.sv
src/dataCache.sv
src/busArbiter.sv
src/wbMemory.sv
src/memSystem.sv
testbench/memSystemTb.sv

// ==== Makefile ====
TOP := memSystemTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -Wall -f sources.f --top-module $(TOP)
	verilator --lint-only -Wall -f sources.f --top-module memSystem

clean:
	rm -rf obj_dir
